//--- pipeline_ctrl.f
+incdir+hdl
hdl/definitions.sv
hdl/decode.sv
hdl/forwarding.sv
hdl/control.sv
hdl/pipe_stage_reg.sv
hdl/pipe_tracker.sv
hdl/pipeline_ctrl.sv
test/pipeline_ctrl_tb.sv

//--- test/pipeline_ctrl_tb.sv
`timescale 1ns/10ps
`include "core_macros.svh"

module pipeline_ctrl_tb;
	import definitions::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 16;
	localparam int MARGIN_CYCLES = 20;
	localparam int FILL_ROWS = 8;

	localparam logic [`INSTR_W-1:0] NOP = 32'h0000_0013;
	localparam logic [`INSTR_W-1:0] ADD_X1_X2_X3 = 32'h0031_00b3;
	localparam logic [`INSTR_W-1:0] ADD_X4_X1_X5 = 32'h0050_8233;
	localparam logic [`INSTR_W-1:0] ADD_X6_X7_X1 = 32'h0013_8333;
	localparam logic [`INSTR_W-1:0] ADD_X8_X1_X9 = 32'h0090_8433;
	localparam logic [`INSTR_W-1:0] LW_X10_X11 = 32'h0005_a503;
	localparam logic [`INSTR_W-1:0] ADD_X12_X10_X13 = 32'h00d5_0633;
	localparam logic [`INSTR_W-1:0] LW_X14_X15 = 32'h0007_a703;
	localparam logic [`INSTR_W-1:0] SW_X16_X17 = 32'h0108_a023;
	localparam logic [`INSTR_W-1:0] BEQ_X18_X19 = 32'h0139_0063;
	localparam logic [`INSTR_W-1:0] JAL_X1 = 32'h0000_00ef;

	localparam alu_out_bypass_t B_NONE = ALU_OUT_BYPASS_FROM_NONE;
	localparam alu_out_bypass_t B_EX = ALU_OUT_BYPASS_FROM_EX;
	localparam alu_out_bypass_t B_MEM = ALU_OUT_BYPASS_FROM_MEM;
	localparam alu_out_bypass_t B_WB = ALU_OUT_BYPASS_FROM_WB;
	localparam next_pc_sel_t PC4 = NEXT_PC_SEL_PC_4;
	localparam next_pc_sel_t ALU = NEXT_PC_SEL_ALU_OUT;

	// One cycle of stimulus and the expected control record.
	typedef struct packed {
		logic [`INSTR_W-1:0] instr;
		logic [`XLEN-1:0] pc;
		logic icache_hit;
		logic dcache_hit;
		logic sb_full;
		logic cmp_res;
		alu_out_bypass_t byp1;
		alu_out_bypass_t byp2;
		next_pc_sel_t next_pc;
		logic pc_stall;
		logic id_stall;
		logic ex_stall;
		logic mem_stall;
		logic id_valid;
		logic ex_valid;
		logic mem_valid;
		logic wb_valid;
		logic valid_load;
		logic sb_put;
	} vector_t;

	logic clk;
	logic rst_n;
	logic [`INSTR_W-1:0] instr;
	logic [`XLEN-1:0] pc;
	logic icache_hit;
	logic dcache_hit;
	logic sb_full;
	logic cmp_res;
	pipeline_control_t control;

	// Word the ID register is expected to hold.
	logic [`INSTR_W-1:0] id_word;

	vector_t vectors[$];
	logic vectors_ready = 1'b0;
	int checks = 0;
	int errors = 0;

	pipeline_ctrl u_dut (
		.clk_i(clk),
		.rst_n_i(rst_n),
		.instr_i(instr),
		.pc_i(pc),
		.icache_hit_i(icache_hit),
		.dcache_hit_i(dcache_hit),
		.store_buffer_full_i(sb_full),
		.cmp_res_i(cmp_res),
		.control_o(control)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Inputs are {icache_hit, dcache_hit, sb_full, cmp_res}.
	// Expected flags are {pc, id, ex, mem stall}_{id, ex, mem, wb valid}_{valid_load, sb_put}.
	task automatic add_row(input logic [`INSTR_W-1:0] i_word, input logic [`XLEN-1:0] i_pc,
		input logic [3:0] ins, input alu_out_bypass_t b1, input alu_out_bypass_t b2,
		input next_pc_sel_t npc, input logic [9:0] exp);
		vector_t v;
		v.instr = i_word;
		v.pc = i_pc;
		{v.icache_hit, v.dcache_hit, v.sb_full, v.cmp_res} = ins;
		v.byp1 = b1;
		v.byp2 = b2;
		v.next_pc = npc;
		{v.pc_stall, v.id_stall, v.ex_stall, v.mem_stall, v.id_valid, v.ex_valid,
			v.mem_valid, v.wb_valid, v.valid_load, v.sb_put} = exp;
		vectors.push_back(v);
	endtask

	// Decode record of each word used in the table.
	// Flags are {uses_rs1, uses_rs2, we, mem, dcache_wr, branch, jump, ecall}.
	function automatic decode_out_t expected_decode(input logic [`INSTR_W-1:0] word);
		case (word)
			NOP: return {5'd0, 5'd0, 5'd0, 8'b1000_0000};
			ADD_X1_X2_X3: return {5'd2, 5'd3, 5'd1, 8'b1110_0000};
			ADD_X4_X1_X5: return {5'd1, 5'd5, 5'd4, 8'b1110_0000};
			ADD_X6_X7_X1: return {5'd7, 5'd1, 5'd6, 8'b1110_0000};
			ADD_X8_X1_X9: return {5'd1, 5'd9, 5'd8, 8'b1110_0000};
			LW_X10_X11: return {5'd11, 5'd0, 5'd10, 8'b1011_0000};
			ADD_X12_X10_X13: return {5'd10, 5'd13, 5'd12, 8'b1110_0000};
			LW_X14_X15: return {5'd15, 5'd0, 5'd14, 8'b1011_0000};
			SW_X16_X17: return {5'd17, 5'd16, 5'd0, 8'b1101_1000};
			BEQ_X18_X19: return {5'd18, 5'd19, 5'd0, 8'b1100_0100};
			JAL_X1: return {5'd0, 5'd0, 5'd1, 8'b0010_0010};
			default: return '0;
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// Vector table
	// ----------------------------------------------------------------------

	task automatic build_vectors();
		int unsigned r;
		// ALU results forwarded at distances one to three.
		add_row(ADD_X1_X2_X3, 32'h00, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1000_00);
		add_row(ADD_X4_X1_X5, 32'h04, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1100_00);
		add_row(ADD_X6_X7_X1, 32'h08, 4'b1100, B_EX, B_NONE, PC4, 10'b0000_1110_00);
		add_row(ADD_X8_X1_X9, 32'h0c, 4'b1100, B_NONE, B_MEM, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'h10, 4'b1100, B_WB, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'h14, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		// Load-use waits until the load reaches WB.
		add_row(LW_X10_X11, 32'h18, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(ADD_X12_X10_X13, 32'h1c, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'h20, 4'b1100, B_NONE, B_NONE, PC4, 10'b1100_1011_00);
		add_row(NOP, 32'h20, 4'b1100, B_NONE, B_NONE, PC4, 10'b1100_1001_10);
		add_row(NOP, 32'h20, 4'b1100, B_WB, B_NONE, PC4, 10'b0000_1100_00);
		// Load miss, then store against a full buffer.
		add_row(LW_X14_X15, 32'h24, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1110_00);
		add_row(SW_X16_X17, 32'h28, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'h2c, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'h30, 4'b1000, B_NONE, B_NONE, PC4, 10'b1111_1110_10);
		add_row(NOP, 32'h30, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_10);
		add_row(NOP, 32'h34, 4'b1110, B_NONE, B_NONE, PC4, 10'b1111_1110_00);
		add_row(NOP, 32'h34, 4'b1110, B_NONE, B_NONE, PC4, 10'b1111_1110_00);
		add_row(NOP, 32'h34, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_01);
		// Taken branch.
		add_row(BEQ_X18_X19, 32'h38, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'h3c, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'h40, 4'b1101, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'h44, 4'b1100, B_NONE, B_NONE, ALU, 10'b0000_0001_00);
		add_row(NOP, 32'h80, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1000_00);
		add_row(NOP, 32'h84, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1100_00);
		// Branch not taken.
		add_row(BEQ_X18_X19, 32'h88, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1110_00);
		add_row(NOP, 32'h8c, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'h90, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'h94, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		// JAL redirects with cmp_res low.
		add_row(JAL_X1, 32'h98, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'h9c, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'ha0, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'ha4, 4'b1100, B_NONE, B_NONE, ALU, 10'b0000_0001_00);
		add_row(NOP, 32'hc0, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1000_00);
		add_row(NOP, 32'hc4, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1100_00);
		// Instruction cache miss alone.
		add_row(NOP, 32'hc8, 4'b0100, B_NONE, B_NONE, PC4, 10'b1000_0110_00);
		add_row(NOP, 32'hc8, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1011_00);
		// Taken branch in MEM during a fetch miss.
		add_row(BEQ_X18_X19, 32'hcc, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1101_00);
		add_row(NOP, 32'hd0, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1110_00);
		add_row(NOP, 32'hd4, 4'b1101, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		add_row(NOP, 32'hd8, 4'b0100, B_NONE, B_NONE, ALU, 10'b1001_0001_00);
		add_row(NOP, 32'hd8, 4'b0100, B_NONE, B_NONE, ALU, 10'b1001_0001_00);
		add_row(NOP, 32'hd8, 4'b1100, B_NONE, B_NONE, ALU, 10'b0000_0001_00);
		add_row(NOP, 32'h100, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1000_00);
		add_row(NOP, 32'h104, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1100_00);
		add_row(NOP, 32'h108, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1110_00);
		add_row(NOP, 32'h10c, 4'b1100, B_NONE, B_NONE, PC4, 10'b0000_1111_00);
		// No memory op in MEM, so the data-side flags are free.
		for (int k = 0; k < FILL_ROWS; k++) begin
			r = $urandom;
			add_row(NOP, 32'h110 + 4 * k, {1'b1, r[0], r[1], 1'b0}, B_NONE, B_NONE, PC4,
				10'b0000_1111_00);
		end
	endtask

	task automatic drive_row(input vector_t v);
		instr = v.instr;
		pc = v.pc;
		icache_hit = v.icache_hit;
		dcache_hit = v.dcache_hit;
		sb_full = v.sb_full;
		cmp_res = v.cmp_res;
	endtask

	task automatic check_field(input int row, input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL row %0d %s: got 0x%0h expected 0x%0h", row, name, got, exp);
		end
	endtask

	task automatic check_row(input int row, input vector_t v);
		check_field(row, "decode_out", control.decode_out, expected_decode(id_word));
		check_field(row, "alu_out_to_reg1_bypass", control.alu_out_to_reg1_bypass, v.byp1);
		check_field(row, "alu_out_to_reg2_bypass", control.alu_out_to_reg2_bypass, v.byp2);
		check_field(row, "next_pc_sel", control.next_pc_sel, v.next_pc);
		check_field(row, "pc_reg_stall", control.pc_reg_stall, v.pc_stall);
		check_field(row, "id_reg_stall", control.id_reg_stall, v.id_stall);
		check_field(row, "ex_reg_stall", control.ex_reg_stall, v.ex_stall);
		check_field(row, "mem_reg_stall", control.mem_reg_stall, v.mem_stall);
		check_field(row, "id_reg_valid", control.id_reg_valid, v.id_valid);
		check_field(row, "ex_reg_valid", control.ex_reg_valid, v.ex_valid);
		check_field(row, "mem_reg_valid", control.mem_reg_valid, v.mem_valid);
		check_field(row, "wb_reg_valid", control.wb_reg_valid, v.wb_valid);
		check_field(row, "mem_valid_load", control.mem_valid_load, v.valid_load);
		check_field(row, "mem_sb_put_enable", control.mem_sb_put_enable, v.sb_put);
	endtask

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------

	initial begin
		int unsigned seed;
		int unsigned r;
		seed = 32'hc47b9392;
		r = $urandom(seed);
		rst_n = 1'b0;
		instr = NOP;
		pc = '0;
		icache_hit = 1'b1;
		dcache_hit = 1'b1;
		sb_full = 1'b0;
		cmp_res = 1'b0;
		id_word = '0;
		build_vectors();
		vectors_ready = 1'b1;

		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;

		// Drive on the falling edge, check ahead of the rising one.
		foreach (vectors[i]) begin
			drive_row(vectors[i]);
			#1;
			check_row(i, vectors[i]);
			// ID takes the fetched word unless it is held.
			if (!vectors[i].id_stall)
				id_word = vectors[i].instr;
			@(negedge clk);
		end

		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin
		wait (vectors_ready);
		#((RESET_CYCLES + vectors.size() + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Watchdog timeout: the vector loop did not finish in time.");
		$display("test failed");
		$finish;
	end
endmodule

//--- hdl/pipeline_ctrl.sv
`timescale 1ns/10ps
`include "core_macros.svh"

module pipeline_ctrl(
	input logic clk_i,
	input logic rst_n_i,
	input logic [`INSTR_W-1:0] instr_i,
	input logic [`XLEN-1:0] pc_i,
	input logic icache_hit_i,
	input logic dcache_hit_i,
	input logic store_buffer_full_i,
	input logic cmp_res_i,
	output definitions::pipeline_control_t control_o
);
	import definitions::*;

	pipeline_id_reg_t id_reg;
	pipeline_ex_reg_t ex_reg;
	pipeline_mem_reg_t mem_reg;
	pipeline_wb_reg_t wb_reg;

	// Stall and valid commands loop back into the stage registers.
	pipe_tracker pipe_tracker(
		.clk_i(clk_i),
		.rst_n_i(rst_n_i),
		.instr_i(instr_i),
		.pc_i(pc_i),
		.cmp_res_i(cmp_res_i),
		.ctrl_i(control_o),
		.id_reg_o(id_reg),
		.ex_reg_o(ex_reg),
		.mem_reg_o(mem_reg),
		.wb_reg_o(wb_reg)
	);

	control control(
		.id_reg_i(id_reg),
		.ex_reg_i(ex_reg),
		.mem_reg_i(mem_reg),
		.wb_reg_i(wb_reg),
		.icache_hit_i(icache_hit_i),
		.dcache_hit_i(dcache_hit_i),
		.store_buffer_full_i(store_buffer_full_i),
		.control_o(control_o)
	);
endmodule

//--- hdl/pipe_tracker.sv
`timescale 1ns/10ps
`include "core_macros.svh"

module pipe_tracker(
	input logic clk_i,
	input logic rst_n_i,
	input logic [`INSTR_W-1:0] instr_i,
	input logic [`XLEN-1:0] pc_i,
	input logic cmp_res_i,
	input definitions::pipeline_control_t ctrl_i,
	output definitions::pipeline_id_reg_t id_reg_o,
	output definitions::pipeline_ex_reg_t ex_reg_o,
	output definitions::pipeline_mem_reg_t mem_reg_o,
	output definitions::pipeline_wb_reg_t wb_reg_o
);
	import definitions::*;

	pipeline_id_reg_t id_next;
	pipeline_ex_reg_t ex_next;
	pipeline_mem_reg_t mem_next;
	pipeline_wb_reg_t wb_next;

	// ------------------------------------------------------------------
	// Next records
	// ------------------------------------------------------------------

	always_comb begin
		// Valid fields are replaced by the commanded ones.
		id_next.valid = 1'b1;
		id_next.pc = pc_i;
		id_next.instr = instr_i;

		ex_next.valid = id_reg_o.valid;
		ex_next.pc = id_reg_o.pc;
		ex_next.regfile_we = ctrl_i.decode_out.regfile_we;
		ex_next.regfile_wr_addr = ctrl_i.decode_out.rd;
		ex_next.is_mem_access = ctrl_i.decode_out.is_mem_access;
		ex_next.dcache_wr_enable = ctrl_i.decode_out.dcache_wr_enable;
		ex_next.is_branch = ctrl_i.decode_out.is_branch;
		ex_next.is_jump = ctrl_i.decode_out.is_jump;
		ex_next.is_ecall = ctrl_i.decode_out.is_ecall;

		mem_next = {ex_reg_o, cmp_res_i};

		wb_next.valid = mem_reg_o.valid;
		wb_next.pc = mem_reg_o.pc;
		wb_next.regfile_we = mem_reg_o.regfile_we;
		wb_next.regfile_wr_addr = mem_reg_o.regfile_wr_addr;
		wb_next.is_ecall = mem_reg_o.is_ecall;
	end

	// ------------------------------------------------------------------
	// Stage registers
	// ------------------------------------------------------------------

	pipe_stage_reg #(.payload_t(pipeline_id_reg_t)) id_stage (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.stall_i(ctrl_i.id_reg_stall), .valid_i(ctrl_i.id_reg_valid),
		.d_i(id_next), .q_o(id_reg_o)
	);

	pipe_stage_reg #(.payload_t(pipeline_ex_reg_t)) ex_stage (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.stall_i(ctrl_i.ex_reg_stall), .valid_i(ctrl_i.ex_reg_valid),
		.d_i(ex_next), .q_o(ex_reg_o)
	);

	pipe_stage_reg #(.payload_t(pipeline_mem_reg_t)) mem_stage (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.stall_i(ctrl_i.mem_reg_stall), .valid_i(ctrl_i.mem_reg_valid),
		.d_i(mem_next), .q_o(mem_reg_o)
	);

	// WB never stalls.
	pipe_stage_reg #(.payload_t(pipeline_wb_reg_t)) wb_stage (
		.clk_i(clk_i), .rst_n_i(rst_n_i),
		.stall_i(1'b0), .valid_i(ctrl_i.wb_reg_valid),
		.d_i(wb_next), .q_o(wb_reg_o)
	);
endmodule

//--- hdl/pipe_stage_reg.sv
`timescale 1ns/10ps

module pipe_stage_reg #(
	parameter type payload_t = definitions::pipeline_wb_reg_t
) (
	input logic clk_i,
	input logic rst_n_i,
	input logic stall_i,
	input logic valid_i,
	input payload_t d_i,
	output payload_t q_o
);
	payload_t d_valid;

	// Next record with the commanded valid.
	always_comb begin
		d_valid = d_i;
		d_valid.valid = valid_i;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			q_o <= '0;
		else if (!stall_i)
			q_o <= d_valid;
	end
endmodule

//--- hdl/control.sv
`timescale 1ns/10ps
`include "core_macros.svh"

module control(
	input definitions::pipeline_id_reg_t id_reg_i,
	input definitions::pipeline_ex_reg_t ex_reg_i,
	input definitions::pipeline_mem_reg_t mem_reg_i,
	input definitions::pipeline_wb_reg_t wb_reg_i,
	input logic icache_hit_i,
	input logic dcache_hit_i,
	input logic store_buffer_full_i,
	output definitions::pipeline_control_t control_o
);
	import definitions::*;

	function automatic logic raw_match(decode_out_t dec, logic valid, logic we,
		logic [`REG_ADDR_W-1:0] rd);
		return valid && we && (rd != '0) &&
			((dec.uses_rs1 && dec.rs1 == rd) || (dec.uses_rs2 && dec.rs2 == rd));
	endfunction

	function automatic alu_out_bypass_t pick_bypass(logic from_ex, logic from_mem,
		logic from_wb);
		if (from_ex)
			return ALU_OUT_BYPASS_FROM_EX;
		else if (from_mem)
			return ALU_OUT_BYPASS_FROM_MEM;
		else if (from_wb)
			return ALU_OUT_BYPASS_FROM_WB;
		return ALU_OUT_BYPASS_FROM_NONE;
	endfunction

	decode_out_t id_dec;
	logic ex_b1, ex_b2, mem_b1, mem_b2, wb_b1, wb_b2;
	logic ex_data_hazard, mem_data_hazard, wb_data_hazard, data_hazard;
	logic control_hazard, icache_busy;
	logic valid_load, valid_store, load_miss, store_and_sb_full, mem_blocked;

	decode decode(
		.instr_i(id_reg_i.instr),
		.decode_o(id_dec)
	);

	forwarding forwarding(
		.id_reg_i(id_reg_i),
		.ex_reg_i(ex_reg_i),
		.mem_reg_i(mem_reg_i),
		.wb_reg_i(wb_reg_i),
		.ex_alu_out_to_reg1_bypass_o(ex_b1),
		.ex_alu_out_to_reg2_bypass_o(ex_b2),
		.mem_alu_out_to_reg1_bypass_o(mem_b1),
		.mem_alu_out_to_reg2_bypass_o(mem_b2),
		.wb_alu_out_to_reg1_bypass_o(wb_b1),
		.wb_alu_out_to_reg2_bypass_o(wb_b2)
	);

	// ------------------------------------------------------------------
	// Hazard detection
	// ------------------------------------------------------------------

	assign ex_data_hazard = raw_match(id_dec, ex_reg_i.valid, ex_reg_i.regfile_we,
		ex_reg_i.regfile_wr_addr) && !(ex_b1 || ex_b2);
	assign mem_data_hazard = raw_match(id_dec, mem_reg_i.valid, mem_reg_i.regfile_we,
		mem_reg_i.regfile_wr_addr) && !(mem_b1 || mem_b2);
	assign wb_data_hazard = raw_match(id_dec, wb_reg_i.valid, wb_reg_i.regfile_we,
		wb_reg_i.regfile_wr_addr) && !(wb_b1 || wb_b2);
	assign data_hazard = ex_data_hazard || mem_data_hazard || wb_data_hazard;

	// Taken branch or jump resolved in MEM.
	assign control_hazard = mem_reg_i.valid &&
		(mem_reg_i.is_jump || (mem_reg_i.is_branch && mem_reg_i.cmp_unit_res));
	assign icache_busy = !icache_hit_i;

	assign valid_load = mem_reg_i.valid && mem_reg_i.is_mem_access &&
		!mem_reg_i.dcache_wr_enable;
	assign valid_store = mem_reg_i.valid && mem_reg_i.is_mem_access &&
		mem_reg_i.dcache_wr_enable;
	assign load_miss = valid_load && !dcache_hit_i;
	assign store_and_sb_full = valid_store && store_buffer_full_i;
	assign mem_blocked = load_miss || store_and_sb_full;

	// ------------------------------------------------------------------
	// Interlock
	// ------------------------------------------------------------------

	always_comb begin
		control_o.decode_out = id_dec;
		control_o.alu_out_to_reg1_bypass = pick_bypass(ex_b1, mem_b1, wb_b1);
		control_o.alu_out_to_reg2_bypass = pick_bypass(ex_b2, mem_b2, wb_b2);
		control_o.next_pc_sel = control_hazard ? NEXT_PC_SEL_ALU_OUT : NEXT_PC_SEL_PC_4;

		control_o.mem_valid_load = valid_load;
		control_o.mem_sb_put_enable = valid_store && !store_buffer_full_i;

		control_o.pc_reg_stall = (data_hazard && !control_hazard) || icache_busy ||
			mem_blocked;
		control_o.id_reg_stall = (data_hazard && !control_hazard) || mem_blocked;
		control_o.id_reg_valid = !control_hazard && !icache_busy;

		control_o.ex_reg_stall = mem_blocked;
		control_o.ex_reg_valid = id_reg_i.valid && !data_hazard && !control_hazard;

		// Keep the redirect alive until the fetch completes.
		control_o.mem_reg_stall = mem_blocked || (icache_busy && control_hazard);
		control_o.mem_reg_valid = ex_reg_i.valid && !control_hazard;

		control_o.wb_reg_valid = mem_reg_i.valid && !mem_blocked;
	end
endmodule

//--- hdl/forwarding.sv
`timescale 1ns/10ps
`include "core_macros.svh"

module forwarding(
	input definitions::pipeline_id_reg_t id_reg_i,
	input definitions::pipeline_ex_reg_t ex_reg_i,
	input definitions::pipeline_mem_reg_t mem_reg_i,
	input definitions::pipeline_wb_reg_t wb_reg_i,
	output logic ex_alu_out_to_reg1_bypass_o,
	output logic ex_alu_out_to_reg2_bypass_o,
	output logic mem_alu_out_to_reg1_bypass_o,
	output logic mem_alu_out_to_reg2_bypass_o,
	output logic wb_alu_out_to_reg1_bypass_o,
	output logic wb_alu_out_to_reg2_bypass_o
);
	import definitions::*;

	decode_out_t id_dec;

	// Source registers of the ID instruction.
	decode decode(
		.instr_i(id_reg_i.instr),
		.decode_o(id_dec)
	);

	function automatic logic can_bypass(logic valid, logic we, logic alu_res,
		logic [`REG_ADDR_W-1:0] rd, logic uses, logic [`REG_ADDR_W-1:0] rs);
		return valid && we && alu_res && uses && (rd != '0) && (rd == rs);
	endfunction

	// Loads in EX or MEM have no ALU result to forward.
	assign ex_alu_out_to_reg1_bypass_o = can_bypass(ex_reg_i.valid, ex_reg_i.regfile_we,
		!ex_reg_i.is_mem_access, ex_reg_i.regfile_wr_addr, id_dec.uses_rs1, id_dec.rs1);
	assign ex_alu_out_to_reg2_bypass_o = can_bypass(ex_reg_i.valid, ex_reg_i.regfile_we,
		!ex_reg_i.is_mem_access, ex_reg_i.regfile_wr_addr, id_dec.uses_rs2, id_dec.rs2);

	assign mem_alu_out_to_reg1_bypass_o = can_bypass(mem_reg_i.valid, mem_reg_i.regfile_we,
		!mem_reg_i.is_mem_access, mem_reg_i.regfile_wr_addr, id_dec.uses_rs1, id_dec.rs1);
	assign mem_alu_out_to_reg2_bypass_o = can_bypass(mem_reg_i.valid, mem_reg_i.regfile_we,
		!mem_reg_i.is_mem_access, mem_reg_i.regfile_wr_addr, id_dec.uses_rs2, id_dec.rs2);

	// WB holds the final write data.
	assign wb_alu_out_to_reg1_bypass_o = can_bypass(wb_reg_i.valid, wb_reg_i.regfile_we,
		1'b1, wb_reg_i.regfile_wr_addr, id_dec.uses_rs1, id_dec.rs1);
	assign wb_alu_out_to_reg2_bypass_o = can_bypass(wb_reg_i.valid, wb_reg_i.regfile_we,
		1'b1, wb_reg_i.regfile_wr_addr, id_dec.uses_rs2, id_dec.rs2);
endmodule

//--- hdl/decode.sv
`timescale 1ns/10ps
`include "core_macros.svh"

module decode(
	input logic [`INSTR_W-1:0] instr_i,
	output definitions::decode_out_t decode_o
);
	import definitions::*;

	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam logic [`INSTR_W-1:0] INSTR_ECALL = 32'h0000_0073;

	logic [6:0] opcode;
	logic [`REG_ADDR_W-1:0] rd;
	logic known;

	assign opcode = instr_i[6:0];
	assign rd = instr_i[11:7];
	assign known = opcode inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH,
		OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC, OPC_SYSTEM};

	always_comb begin
		decode_o = '0;

		case (opcode)
			OPC_OP: begin
				decode_o.uses_rs1 = 1'b1;
				decode_o.uses_rs2 = 1'b1;
				decode_o.regfile_we = 1'b1;
			end
			OPC_OP_IMM: begin
				decode_o.uses_rs1 = 1'b1;
				decode_o.regfile_we = 1'b1;
			end
			OPC_LOAD: begin
				decode_o.uses_rs1 = 1'b1;
				decode_o.regfile_we = 1'b1;
				decode_o.is_mem_access = 1'b1;
			end
			OPC_STORE: begin
				decode_o.uses_rs1 = 1'b1;
				decode_o.uses_rs2 = 1'b1;
				decode_o.is_mem_access = 1'b1;
				decode_o.dcache_wr_enable = 1'b1;
			end
			OPC_BRANCH: begin
				decode_o.uses_rs1 = 1'b1;
				decode_o.uses_rs2 = 1'b1;
				decode_o.is_branch = 1'b1;
			end
			OPC_JAL: begin
				decode_o.regfile_we = 1'b1;
				decode_o.is_jump = 1'b1;
			end
			OPC_JALR: begin
				decode_o.uses_rs1 = 1'b1;
				decode_o.regfile_we = 1'b1;
				decode_o.is_jump = 1'b1;
			end
			OPC_LUI, OPC_AUIPC: decode_o.regfile_we = 1'b1;
			OPC_SYSTEM: decode_o.is_ecall = (instr_i == INSTR_ECALL);
			default: ;
		endcase

		// Register fields only for a recognised class.
		if (known) begin
			decode_o.rd = rd;
			decode_o.rs1 = instr_i[19:15];
			decode_o.rs2 = instr_i[24:20];
		end

		// Writes to x0 are dropped.
		if (rd == '0)
			decode_o.regfile_we = 1'b0;
	end
endmodule

//--- hdl/definitions.sv
package definitions;

`include "core_macros.svh"

	// ------------------------------------------------------------------
	// Selectors
	// ------------------------------------------------------------------

	typedef enum logic [1:0] {
		ALU_OUT_BYPASS_FROM_NONE,
		ALU_OUT_BYPASS_FROM_EX,
		ALU_OUT_BYPASS_FROM_MEM,
		ALU_OUT_BYPASS_FROM_WB
	} alu_out_bypass_t;

	typedef enum logic {
		NEXT_PC_SEL_PC_4,
		NEXT_PC_SEL_ALU_OUT
	} next_pc_sel_t;

	// ------------------------------------------------------------------
	// Decode record of the ID instruction
	// ------------------------------------------------------------------

	typedef struct packed {
		logic [`REG_ADDR_W-1:0] rs1;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rd;
		logic uses_rs1;
		logic uses_rs2;
		logic regfile_we;
		logic is_mem_access;
		logic dcache_wr_enable;
		logic is_branch;
		logic is_jump;
		logic is_ecall;
	} decode_out_t;

	// ------------------------------------------------------------------
	// Stage records
	// ------------------------------------------------------------------

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] pc;
		logic [`INSTR_W-1:0] instr;
	} pipeline_id_reg_t;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] pc;
		logic regfile_we;
		logic [`REG_ADDR_W-1:0] regfile_wr_addr;
		logic is_mem_access;
		logic dcache_wr_enable;
		logic is_branch;
		logic is_jump;
		logic is_ecall;
	} pipeline_ex_reg_t;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] pc;
		logic regfile_we;
		logic [`REG_ADDR_W-1:0] regfile_wr_addr;
		logic is_mem_access;
		logic dcache_wr_enable;
		logic is_branch;
		logic is_jump;
		logic is_ecall;
		logic cmp_unit_res;
	} pipeline_mem_reg_t;

	typedef struct packed {
		logic valid;
		logic [`XLEN-1:0] pc;
		logic regfile_we;
		logic [`REG_ADDR_W-1:0] regfile_wr_addr;
		logic is_ecall;
	} pipeline_wb_reg_t;

	// Per-cycle control record.
	typedef struct packed {
		decode_out_t decode_out;
		alu_out_bypass_t alu_out_to_reg1_bypass;
		alu_out_bypass_t alu_out_to_reg2_bypass;
		next_pc_sel_t next_pc_sel;
		logic mem_valid_load;
		logic mem_sb_put_enable;
		logic pc_reg_stall;
		logic id_reg_stall;
		logic id_reg_valid;
		logic ex_reg_stall;
		logic ex_reg_valid;
		logic mem_reg_stall;
		logic mem_reg_valid;
		logic wb_reg_valid;
	} pipeline_control_t;

endpackage

//--- hdl/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// ----------------------------------------------------------------------
// Core widths
// ----------------------------------------------------------------------

// Data path and PC width.
`define XLEN 32

// Register index width, 32 architectural registers.
`define REG_ADDR_W 5

// Fetched instruction word.
`define INSTR_W 32

`endif
